// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath word width
`define DATA_W 32

// Register index width and file depth
`define REG_ADDR_W 5
`define NUM_REGS 32

// Hardware stack pointer lives in r29
`define SP_REG 29

// Top of stack after reset
`define SP_RESET 12'hFFF

`endif

// ==== cpu_types_pkg.sv ====
`include "cpu_config.svh"

package cpu_types_pkg;

	// Data, PC and ALU operands
	typedef logic [`DATA_W-1:0] word_t;

	// Register file index
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	typedef logic [15:0] imm16_t;	// I-type immediate
	typedef logic [25:0] imm26_t;	// J-type immediate

	// Shift amount field
	typedef logic [4:0] shamt_t;

endpackage

// ==== cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	// Opcode field, bits 31:26; unlisted codes decode as NOP
	typedef enum logic [5:0] {
		ADD  = 6'd1,
		SUB  = 6'd2,
		AND  = 6'd3,
		NAND = 6'd4,
		XOR  = 6'd5,
		ADDI = 6'd6,
		ANDI = 6'd7,
		LW   = 6'd8,
		SW   = 6'd9,
		BEQ  = 6'd10,
		JMP  = 6'd11,
		SLL  = 6'd12,
		SRL  = 6'd13,
		PUSH = 6'd14,
		POP  = 6'd15,
		CALL = 6'd16,
		RET  = 6'd17
	} opcode_t;

	// ALU operand mux select
	typedef logic [1:0] alu_src_t;

	localparam alu_src_t ALU_SRC_RR  = 2'd0;	// Register / register
	localparam alu_src_t ALU_SRC_IMM = 2'd1;	// Register or PC / immediate
	localparam alu_src_t ALU_SRC_SH  = 2'd2;	// Shift amount or stack step

	// One side of a four-phase handshake
	typedef enum logic [1:0] {EMPTY, FULL, WAIT_DROP} hs_state_t;

endpackage

// ==== regfile.sv ====
`include "cpu_config.svh"

module regfile
	import cpu_types_pkg::*;
(
	input  logic      clk,
	input  logic      we,
	input  reg_addr_t waddr,
	input  word_t     wdata,
	input  reg_addr_t raddr_1,
	input  reg_addr_t raddr_2,
	input  logic      ren_1,
	input  logic      ren_2,
	output word_t     rdata_1,
	output word_t     rdata_2
);

	// Storage array, contents undefined until written
	word_t mem [`NUM_REGS];

	// Single synchronous write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Asynchronous reads, gated to zero when the port is idle
	// No bypass, a same-cycle write shows up one cycle later
	assign rdata_1 = ren_1 ? mem[raddr_1] : '0;
	assign rdata_2 = ren_2 ? mem[raddr_2] : '0;

endmodule

// ==== ctrl_decode.sv ====
module ctrl_decode
	import cpu_ctrl_pkg::*;
(
	input  opcode_t  op,
	output logic     call,
	output logic     ret,
	output logic     branch,
	output logic     push_pop,
	output logic     pop,
	output logic     reg_2_sel,
	output logic     sign_ext_sel,
	output logic     ren_1,
	output logic     ren_2,
	output alu_src_t alu_src
);

	always_comb begin
		// NOP defaults, nothing read
		call         = 1'b0;
		ret          = 1'b0;
		branch       = 1'b0;
		push_pop     = 1'b0;
		pop          = 1'b0;
		reg_2_sel    = 1'b0;
		sign_ext_sel = 1'b0;
		ren_1        = 1'b0;
		ren_2        = 1'b0;
		alu_src      = ALU_SRC_RR;

		case (op)
			ADD, SUB, AND, NAND, XOR: begin
				alu_src   = ALU_SRC_RR;
				ren_1     = 1'b1;
				ren_2     = 1'b1;
				reg_2_sel = 1'b1;	// Port 2 takes rt
			end
			ADDI, ANDI, LW: begin
				alu_src = ALU_SRC_IMM;
				ren_1   = 1'b1;
			end
			SW: begin
				alu_src = ALU_SRC_IMM;
				ren_1   = 1'b1;
				ren_2   = 1'b1;	// Store data from rd
			end
			BEQ, JMP: begin
				alu_src      = ALU_SRC_IMM;
				ren_1        = 1'b1;
				branch       = 1'b1;	// PC goes to ALU port A
				sign_ext_sel = (op == JMP);	// Long J-type offset
			end
			SLL, SRL: begin
				alu_src = ALU_SRC_SH;
				ren_1   = 1'b1;
			end
			PUSH, POP: begin
				alu_src  = ALU_SRC_SH;
				ren_1    = 1'b1;
				ren_2    = (op == PUSH);	// Pushed value from rd
				push_pop = 1'b1;
				pop      = (op == POP);
			end
			CALL: begin
				alu_src = ALU_SRC_SH;
				ren_1   = 1'b1;
				call    = 1'b1;
			end
			RET: begin
				alu_src = ALU_SRC_SH;
				ren_1   = 1'b1;
				ret     = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== id_unit.sv ====
`include "cpu_config.svh"

module id_unit
	import cpu_types_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      call,
	input  logic      ret,
	input  logic      branch,
	input  logic      push_pop,
	input  logic      pop,
	input  logic      reg_2_sel,
	input  logic      sign_ext_sel,
	input  logic      ren_1,
	input  logic      ren_2,
	input  alu_src_t  alu_src,
	input  logic      wb_we,
	input  reg_addr_t wb_reg,
	input  word_t     wb_data,
	input  reg_addr_t rd,
	input  reg_addr_t rs,
	input  reg_addr_t rt,
	input  shamt_t    shamt,
	input  imm16_t    imm16,
	input  imm26_t    imm26,
	input  word_t     pc,
	output word_t     alu_a,
	output word_t     alu_b,
	output word_t     store_data,
	output reg_addr_t dest
);

	logic      sp_access;	// Instruction touches the stack pointer
	reg_addr_t raddr_1;
	reg_addr_t raddr_2;
	word_t     rdata_1;
	word_t     rdata_2;
	word_t     sext;	// Sign-extended immediate
	logic      rf_we;
	reg_addr_t rf_waddr;
	word_t     rf_wdata;

	assign sp_access = call | ret | push_pop | pop;

	assign raddr_1 = sp_access ? reg_addr_t'(`SP_REG) : rs;	// SP replaces rs
	assign raddr_2 = reg_2_sel ? rt : rd;

	assign store_data = rdata_2;
	assign dest       = rd;

	// J-type offset for JMP, otherwise I-type
	assign sext = sign_ext_sel ? {{($bits(word_t) - 26){imm26[25]}}, imm26}
	                           : {{($bits(word_t) - 16){imm16[15]}}, imm16};

	// Reset keeps hammering the initial SP into r29
	always_comb begin
		if (rst) begin
			rf_we    = 1'b1;
			rf_waddr = reg_addr_t'(`SP_REG);
			rf_wdata = word_t'(`SP_RESET);
		end else begin
			rf_we    = wb_we;
			rf_waddr = wb_reg;
			rf_wdata = wb_data;
		end
	end

	regfile u_regfile (
		.clk     (clk),
		.we      (rf_we),
		.waddr   (rf_waddr),
		.wdata   (rf_wdata),
		.raddr_1 (raddr_1),
		.raddr_2 (raddr_2),
		.ren_1   (ren_1),
		.ren_2   (ren_2),
		.rdata_1 (rdata_1),
		.rdata_2 (rdata_2)
	);

	// ALU operand mux
	always_comb begin
		case (alu_src)
			ALU_SRC_RR: begin
				alu_a = rdata_1;
				alu_b = rdata_2;
			end
			ALU_SRC_IMM: begin
				alu_a = branch ? pc : rdata_1;	// Branch target off PC
				alu_b = sext;
			end
			ALU_SRC_SH: begin
				alu_a = rdata_1;
				alu_b = sp_access ? word_t'(1) : word_t'(shamt);	// SP step of one
			end
			default: begin
				alu_a = '0;
				alu_b = '0;
			end
		endcase
	end

endmodule

// ==== id_pipe_regs.sv ====
module id_pipe_regs
	import cpu_types_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      if_req,
	output logic      if_ack,
	input  word_t     if_instr,
	input  word_t     if_pc,
	output word_t     id_instr,
	output word_t     id_pc,
	input  word_t     alu_a,
	input  word_t     alu_b,
	input  word_t     store_data,
	input  reg_addr_t dest,
	output logic      ex_req,
	input  logic      ex_ack,
	output opcode_t   ex_op,
	output word_t     ex_alu_a,
	output word_t     ex_alu_b,
	output word_t     ex_store_data,
	output reg_addr_t ex_dest,
	output word_t     ex_pc
);

	hs_state_t in_st;	// IF/ID occupancy plus pending req drop
	hs_state_t out_st;	// ID/EX handshake phase
	logic      capture;
	logic      transfer;

	assign capture  = if_req && !if_ack && (in_st == EMPTY);
	assign transfer = (in_st == FULL) && (out_st == EMPTY);

	// Fetch side
	always_ff @(posedge clk) begin
		if (rst) begin
			in_st  <= EMPTY;
			if_ack <= 1'b0;
		end else begin
			if (capture) begin
				if_ack <= 1'b1;
			end else if (if_ack && !if_req) begin
				if_ack <= 1'b0;	// Drop one cycle after req seen low
			end
			case (in_st)
				EMPTY:     if (capture) in_st <= FULL;
				FULL:      if (transfer) in_st <= (if_ack && if_req) ? WAIT_DROP : EMPTY;
				WAIT_DROP: if (!if_req) in_st <= EMPTY;	// Item gone, ack still up
				default:   in_st <= EMPTY;
			endcase
		end
	end

	// Execute side, free only after ack seen low
	always_ff @(posedge clk) begin
		if (rst) begin
			out_st <= EMPTY;
		end else begin
			case (out_st)
				EMPTY:     if (transfer) out_st <= FULL;
				FULL:      if (ex_ack) out_st <= WAIT_DROP;
				WAIT_DROP: if (!ex_ack) out_st <= EMPTY;
				default:   out_st <= EMPTY;
			endcase
		end
	end

	assign ex_req = (out_st == FULL);

	// Payload registers
	always_ff @(posedge clk) begin
		if (capture) begin
			id_instr <= if_instr;
			id_pc    <= if_pc;
		end
		if (transfer) begin
			ex_op         <= opcode_t'(id_instr[31:26]);
			ex_alu_a      <= alu_a;	// Decoded from IF/ID contents this cycle
			ex_alu_b      <= alu_b;
			ex_store_data <= store_data;
			ex_dest       <= dest;
			ex_pc         <= id_pc;
		end
	end

endmodule

// ==== id_stage_top.sv ====
module id_stage_top
	import cpu_types_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      if_req,
	output logic      if_ack,
	input  word_t     if_instr,
	input  word_t     if_pc,
	input  logic      wb_we,
	input  reg_addr_t wb_reg,
	input  word_t     wb_data,
	output logic      ex_req,
	input  logic      ex_ack,
	output opcode_t   ex_op,
	output word_t     ex_alu_a,
	output word_t     ex_alu_b,
	output word_t     ex_store_data,
	output reg_addr_t ex_dest,
	output word_t     ex_pc
);

	word_t     id_instr;
	word_t     id_pc;
	logic      call;
	logic      ret;
	logic      branch;
	logic      push_pop;
	logic      pop;
	logic      reg_2_sel;
	logic      sign_ext_sel;
	logic      ren_1;
	logic      ren_2;
	alu_src_t  alu_src;
	word_t     alu_a;
	word_t     alu_b;
	word_t     store_data;
	reg_addr_t dest;

	id_pipe_regs u_id_pipe_regs (
		.clk (clk), .rst (rst),
		.if_req (if_req), .if_ack (if_ack),
		.if_instr (if_instr), .if_pc (if_pc),
		.id_instr (id_instr), .id_pc (id_pc),
		.alu_a (alu_a), .alu_b (alu_b),
		.store_data (store_data), .dest (dest),
		.ex_req (ex_req), .ex_ack (ex_ack), .ex_op (ex_op),
		.ex_alu_a (ex_alu_a), .ex_alu_b (ex_alu_b),
		.ex_store_data (ex_store_data), .ex_dest (ex_dest), .ex_pc (ex_pc)
	);

	// Opcode field straight off the IF/ID register
	ctrl_decode u_ctrl_decode (
		.op (opcode_t'(id_instr[31:26])),
		.call (call), .ret (ret), .branch (branch),
		.push_pop (push_pop), .pop (pop),
		.reg_2_sel (reg_2_sel), .sign_ext_sel (sign_ext_sel),
		.ren_1 (ren_1), .ren_2 (ren_2), .alu_src (alu_src)
	);

	id_unit u_id_unit (
		.clk (clk), .rst (rst),
		.call (call), .ret (ret), .branch (branch),
		.push_pop (push_pop), .pop (pop),
		.reg_2_sel (reg_2_sel), .sign_ext_sel (sign_ext_sel),
		.ren_1 (ren_1), .ren_2 (ren_2), .alu_src (alu_src),
		.wb_we (wb_we), .wb_reg (wb_reg), .wb_data (wb_data),
		.rd (id_instr[25:21]),	// Destination, also store source
		.rs (id_instr[20:16]),
		.rt (id_instr[15:11]),
		.shamt (id_instr[10:6]),
		.imm16 (id_instr[15:0]),	// Overlaps rt and shamt
		.imm26 (id_instr[25:0]),
		.pc (id_pc),
		.alu_a (alu_a), .alu_b (alu_b),
		.store_data (store_data), .dest (dest)
	);

endmodule

// ==== id_stage_sva.sv ====
module id_stage_sva
	import cpu_types_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      if_req,
	input logic      if_ack,
	input logic      ex_req,
	input logic      ex_ack,
	input opcode_t   ex_op,
	input word_t     ex_alu_a,
	input word_t     ex_alu_b,
	input word_t     ex_store_data,
	input reg_addr_t ex_dest,
	input word_t     ex_pc
);

	// Request and payload frozen until the consumer answers
	property ex_hold;
		@(posedge clk) disable iff (rst)
		ex_req && !ex_ack |=> ex_req && $stable(ex_op) && $stable(ex_alu_a)
			&& $stable(ex_alu_b) && $stable(ex_store_data) && $stable(ex_dest)
			&& $stable(ex_pc);
	endproperty

	assert property (ex_hold) else $error("ex_req or its payload changed before ex_ack");

	assert property (@(posedge clk) rst |=> !if_ack)	// Ack low coming out of reset
		else $error("if_ack high in the cycle after reset");

	// No new ack without a pending request
	assert property (@(posedge clk) disable iff (rst) !if_req && !if_ack |=> !if_ack)
		else $error("if_ack rose while if_req was low");

endmodule

bind id_pipe_regs id_stage_sva u_id_stage_sva (
	.clk (clk), .rst (rst),
	.if_req (if_req), .if_ack (if_ack),
	.ex_req (ex_req), .ex_ack (ex_ack), .ex_op (ex_op),
	.ex_alu_a (ex_alu_a), .ex_alu_b (ex_alu_b),
	.ex_store_data (ex_store_data), .ex_dest (ex_dest), .ex_pc (ex_pc)
);

// ==== tb_id_stage.sv ====
`include "cpu_config.svh"

module tb_id_stage
	import cpu_types_pkg::*;
	import cpu_ctrl_pkg::*;
();

	localparam int TIMEOUT = 200;	// Cycles allowed per wait loop

	logic      clk;
	logic      rst;
	logic      if_req;
	logic      if_ack;
	word_t     if_instr;
	word_t     if_pc;
	logic      wb_we;
	reg_addr_t wb_reg;
	word_t     wb_data;
	logic      ex_req;
	logic      ex_ack;
	opcode_t   ex_op;
	word_t     ex_alu_a;
	word_t     ex_alu_b;
	word_t     ex_store_data;
	reg_addr_t ex_dest;
	word_t     ex_pc;

	word_t       model [32];	// Expected register contents
	logic [31:0] lfsr_state;
	int          errors;
	int          checks;

	// Last payload taken from the execute side
	opcode_t   got_op;
	word_t     got_a;
	word_t     got_b;
	word_t     got_sd;
	word_t     got_pc;
	reg_addr_t got_dest;

	id_stage_top u_id_stage_top (
		.clk (clk), .rst (rst),
		.if_req (if_req), .if_ack (if_ack), .if_instr (if_instr), .if_pc (if_pc),
		.wb_we (wb_we), .wb_reg (wb_reg), .wb_data (wb_data),
		.ex_req (ex_req), .ex_ack (ex_ack), .ex_op (ex_op),
		.ex_alu_a (ex_alu_a), .ex_alu_b (ex_alu_b),
		.ex_store_data (ex_store_data), .ex_dest (ex_dest), .ex_pc (ex_pc)
	);

	always #2 clk = ~clk;

	// Galois LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic word_t rand_bits(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};	// One step per bit
		end
		return v;
	endfunction

	function automatic reg_addr_t rand_reg();
		word_t w;
		w = rand_bits(5);
		return w[4:0];
	endfunction

	function automatic word_t sext16(imm16_t imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic word_t sext26(imm26_t imm);
		return {{6{imm[25]}}, imm};
	endfunction

	// Instruction encoders
	function automatic word_t enc_r(opcode_t op, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
		shamt_t sh);
		return {op, rd, rs, rt, sh, 6'b0};
	endfunction

	function automatic word_t enc_i(opcode_t op, reg_addr_t rd, reg_addr_t rs, imm16_t imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic word_t enc_j(opcode_t op, imm26_t imm);
		return {op, imm};
	endfunction

	task automatic check_word(string name, word_t exp, word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_op(string name, opcode_t exp, opcode_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Inputs change 1 unit after the edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic wb_write(reg_addr_t r, word_t d);
		wb_we   = 1'b1;
		wb_reg  = r;
		wb_data = d;
		tick();
		wb_we = 1'b0;
		model[r] = d;
	endtask

	task automatic start_send(word_t instr, word_t pc);
		if_req   = 1'b1;
		if_instr = instr;
		if_pc    = pc;
	endtask

	// Ack, drop request, wait for ack to fall
	task automatic finish_send(string name);
		int n;
		n = 0;
		while (!if_ack && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (!if_ack) begin
			errors++;
			$display("%s: fetch request never got if_ack", name);
		end
		if_req = 1'b0;
		n = 0;
		while (if_ack && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (if_ack) begin
			errors++;
			$display("%s: if_ack stayed high after if_req dropped", name);
		end
	endtask

	task automatic send_instr(string name, word_t instr, word_t pc);
		start_send(instr, pc);
		finish_send(name);
	endtask

	task automatic take_result(string name);
		int n;
		n = 0;
		while (!ex_req && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (!ex_req) begin
			errors++;
			$display("%s: ex_req never rose", name);
		end
		got_op   = ex_op;
		got_a    = ex_alu_a;
		got_b    = ex_alu_b;
		got_sd   = ex_store_data;
		got_dest = ex_dest;
		got_pc   = ex_pc;
		ex_ack = 1'b1;
		n = 0;
		while (ex_req && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (ex_req) begin
			errors++;
			$display("%s: ex_req stayed high after ex_ack", name);
		end
		ex_ack = 1'b0;
	endtask

	// Opcode and dest come straight from the instruction fields
	task automatic expect_result(string name, word_t instr, word_t pc, word_t a, word_t b,
		word_t sd);
		opcode_t   op;
		reg_addr_t rd;
		op = opcode_t'(instr[31:26]);
		rd = instr[25:21];
		check_op({name, " op"}, op, got_op);
		check_word({name, " alu_a"}, a, got_a);
		check_word({name, " alu_b"}, b, got_b);
		check_word({name, " store_data"}, sd, got_sd);
		check_addr({name, " dest"}, rd, got_dest);
		check_word({name, " pc"}, pc, got_pc);
	endtask

	task automatic run_instr(string name, word_t instr, word_t pc, word_t a, word_t b,
		word_t sd);
		send_instr(name, instr, pc);
		take_result(name);
		expect_result(name, instr, pc, a, b, sd);
	endtask

	// Fill every register except SP
	task automatic init_regs();
		reg_addr_t idx;
		for (int r = 0; r < 32; r++) begin
			idx = r[4:0];
			if (r != `SP_REG) wb_write(idx, rand_bits(32));
		end
	endtask

	task automatic test_stack();
		reg_addr_t rd;
		word_t     sp;
		sp = word_t'(`SP_RESET);
		rd = rand_reg();
		run_instr("push", enc_r(PUSH, rd, rand_reg(), rand_reg(), 5'd0), rand_bits(32),
			sp, 32'd1, model[rd]);
		run_instr("call", enc_r(CALL, rand_reg(), rand_reg(), 5'd0, 5'd0), rand_bits(32),
			sp, 32'd1, 32'd0);
		run_instr("ret", enc_r(RET, rand_reg(), rand_reg(), 5'd0, 5'd0), rand_bits(32),
			sp, 32'd1, 32'd0);
	endtask

	task automatic test_rtype();
		opcode_t   ops [5] = '{ADD, SUB, AND, NAND, XOR};
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t w;
		for (int i = 0; i < 6; i++) begin
			w = rand_reg();
			if (w == `SP_REG) w = 5'd30;	// Keep SP intact
			wb_write(w, rand_bits(32));
		end
		for (int i = 0; i < 5; i++) begin
			rd = rand_reg();
			rs = rand_reg();
			rt = rand_reg();
			run_instr(ops[i].name(), enc_r(ops[i], rd, rs, rt, rand_reg()), rand_bits(32),
				model[rs], model[rt], model[rt]);	// Port 2 reads rt
		end
	endtask

	task automatic test_imm();
		opcode_t   ops [3] = '{ADDI, ANDI, LW};
		reg_addr_t rd;
		reg_addr_t rs;
		imm16_t    imm;
		imm26_t    imm26;
		word_t     w;
		word_t     pc;
		for (int i = 0; i < 6; i++) begin
			rs = rand_reg();
			w = rand_bits(16);
			imm = w[15:0];
			if (i < 3) imm[15] = 1'b1;	// Negative pass first
			run_instr(ops[i % 3].name(), enc_i(ops[i % 3], rand_reg(), rs, imm),
				rand_bits(32), model[rs], sext16(imm), 32'd0);
		end
		rd = rand_reg();
		rs = rand_reg();
		w = rand_bits(16);
		imm = w[15:0];
		run_instr("sw", enc_i(SW, rd, rs, imm), rand_bits(32), model[rs], sext16(imm), model[rd]);
		pc = rand_bits(32);
		imm = 16'h8003;
		run_instr("beq", enc_i(BEQ, rand_reg(), rand_reg(), imm), pc, pc, sext16(imm), 32'd0);
		pc = rand_bits(32);
		w = rand_bits(26);
		imm26 = {1'b1, w[24:0]};	// Negative long offset
		run_instr("jmp", enc_j(JMP, imm26), pc, pc, sext26(imm26), 32'd0);
	endtask

	task automatic test_shift();
		reg_addr_t rs;
		shamt_t    sh;
		rs = rand_reg();
		sh = rand_reg();
		run_instr("sll", enc_r(SLL, rand_reg(), rs, rand_reg(), sh), rand_bits(32),
			model[rs], word_t'(sh), 32'd0);
		rs = rand_reg();
		sh = rand_reg();
		run_instr("srl", enc_r(SRL, rand_reg(), rs, rand_reg(), sh), rand_bits(32),
			model[rs], word_t'(sh), 32'd0);
		run_instr("nop", enc_r(opcode_t'(6'd63), rand_reg(), rand_reg(), rand_reg(), 5'd0),
			rand_bits(32), 32'd0, 32'd0, 32'd0);	// Undefined code reads nothing
	endtask

	// ex_ack held low, two in flight, third must stall
	task automatic test_backpressure();
		word_t     ins [3];
		word_t     pcs [3];
		reg_addr_t rs [3];
		reg_addr_t rt [3];
		opcode_t   ops [3] = '{ADD, SUB, XOR};
		logic      acked;
		for (int i = 0; i < 3; i++) begin
			rs[i] = rand_reg();
			rt[i] = rand_reg();
			ins[i] = enc_r(ops[i], rand_reg(), rs[i], rt[i], 5'd0);
			pcs[i] = rand_bits(32);
		end
		send_instr("bp first", ins[0], pcs[0]);
		send_instr("bp second", ins[1], pcs[1]);
		start_send(ins[2], pcs[2]);
		acked = 1'b0;
		for (int n = 0; n < 8; n++) begin
			tick();
			if (if_ack) acked = 1'b1;
		end
		checks++;
		if (acked) begin
			errors++;
			$display("bp third: if_ack rose while both registers were full");
		end
		take_result("bp first");
		expect_result("bp first", ins[0], pcs[0], model[rs[0]], model[rt[0]], model[rt[0]]);
		finish_send("bp third");
		take_result("bp second");
		expect_result("bp second", ins[1], pcs[1], model[rs[1]], model[rt[1]], model[rt[1]]);
		take_result("bp third");
		expect_result("bp third", ins[2], pcs[2], model[rs[2]], model[rt[2]], model[rt[2]]);
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		if_req     = 1'b0;
		if_instr   = '0;
		if_pc      = '0;
		wb_we      = 1'b0;
		wb_reg     = '0;
		wb_data    = '0;
		ex_ack     = 1'b0;
		lfsr_state = 32'h0a331215;
		errors     = 0;
		checks     = 0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		model[`SP_REG] = word_t'(`SP_RESET);	// Written by the reset override
		init_regs();
		test_stack();
		test_rtype();
		test_imm();
		test_shift();
		test_backpressure();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
cpu_types_pkg.sv
cpu_ctrl_pkg.sv
regfile.sv
ctrl_decode.sv
id_unit.sv
id_pipe_regs.sv
id_stage_top.sv
id_stage_sva.sv
tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_id_stage -o sim_tb_id_stage
if [ $? -ne 0 ]; then
	echo "Verilator build error"
	exit 1
fi

./obj_dir/sim_tb_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0
